// ==== rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32
`define IMEM_ADDR_W 30  // word address
`define DMEM_ADDR_W 30

`define OPC_RTYPE  7'b0110011
`define OPC_ITYPE  7'b0010011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111

`define ALU_CTRL_W 4
`define ALU_AND 4'b0000
`define ALU_OR  4'b0001
`define ALU_ADD 4'b0010
`define ALU_SLL 4'b0011
`define ALU_SRL 4'b0100
`define ALU_SRA 4'b0101
`define ALU_SUB 4'b0110
`define ALU_SLT 4'b0111
`define ALU_XOR 4'b1000

`define FWD_REG 2'b00  // register file value
`define FWD_WB  2'b01
`define FWD_MEM 2'b10

`endif

// ==== rvIsaPkg.sv ====
package rvIsaPkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeFields;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeFields;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sTypeFields;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeFields;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jTypeFields;

    // one fetched word, five ways to read it
    typedef union packed {
        rTypeFields rType;
        iTypeFields iType;
        sTypeFields sType;
        bTypeFields bType;
        jTypeFields jType;
    } instrWord;

endpackage

// ==== regFile.sv ====
`include "rv_defines.svh"

module regFile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic [`XLEN-1:0]       wData,
    input  logic                   we,
    output logic [`XLEN-1:0]       rData1,
    output logic [`XLEN-1:0]       rData2
);
    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic             wrActive;

    assign wrActive = we && (rd != '0);  // x0 never written

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrActive) begin
            regs[rd] <= wData;
        end
    end

    // write-through so decode sees the writeback of this cycle
    assign rData1 = (wrActive && rd == rs1) ? wData : regs[rs1];
    assign rData2 = (wrActive && rd == rs2) ? wData : regs[rs2];

endmodule

// ==== aluUnit.sv ====
`include "rv_defines.svh"

module aluUnit (
    input  logic [`XLEN-1:0]       a,
    input  logic [`XLEN-1:0]       b,
    input  logic [`ALU_CTRL_W-1:0] aluCtrl,
    output logic [`XLEN-1:0]       result
);
    logic [4:0]       shamt;
    logic [`XLEN-1:0] sraResult;
    logic             lessThan;

    assign shamt     = b[4:0];
    assign sraResult = $signed(a) >>> shamt;
    assign lessThan  = $signed(a) < $signed(b);  // signed compare

    always_comb begin
        case (aluCtrl)
            `ALU_AND: begin
                result = a & b;
            end
            `ALU_OR: begin
                result = a | b;
            end
            `ALU_XOR: begin
                result = a ^ b;
            end
            `ALU_ADD: begin
                result = a + b;
            end
            `ALU_SUB: begin
                result = a - b;
            end
            `ALU_SLT: begin
                result = {{(`XLEN-1){1'b0}}, lessThan};
            end
            `ALU_SLL: begin
                result = a << shamt;
            end
            `ALU_SRL: begin
                result = a >> shamt;
            end
            `ALU_SRA: begin
                result = sraResult;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== instrDecoder.sv ====
`include "rv_defines.svh"

module instrDecoder (
    input  rvIsaPkg::instrWord           instr,
    output logic                         regWrite,
    output logic                         memRead,
    output logic                         memWrite,
    output logic                         memToReg,
    output logic                         aluSrc,
    output logic                         isBranch,
    output logic                         isJal,
    output logic                         branchOnNe,
    output logic [`ALU_CTRL_W-1:0]       aluCtrl,
    output logic [`XLEN-1:0]             imm
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       altOp;

    assign opcode = instr.rType.opcode;
    assign funct3 = instr.rType.funct3;
    assign altOp  = instr.rType.funct7[5];  // sub / sra select

    always_comb begin
        regWrite   = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        memToReg   = 1'b0;
        aluSrc     = 1'b0;
        isBranch   = 1'b0;
        isJal      = 1'b0;
        branchOnNe = 1'b0;
        case (opcode)
            `OPC_RTYPE: begin
                regWrite = 1'b1;
            end
            `OPC_ITYPE: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            `OPC_LOAD: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
                aluSrc   = 1'b1;
            end
            `OPC_STORE: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            `OPC_BRANCH: begin
                isBranch   = 1'b1;
                branchOnNe = funct3[0];  // bne
            end
            `OPC_JAL: begin
                regWrite = 1'b1;
                isJal    = 1'b1;
            end
            default: begin
                regWrite = 1'b0;  // bubble
            end
        endcase
    end

    always_comb begin
        aluCtrl = '0;
        if (opcode == `OPC_LOAD || opcode == `OPC_STORE) begin
            aluCtrl = `ALU_ADD;  // address calc
        end else if (opcode == `OPC_RTYPE || opcode == `OPC_ITYPE) begin
            case (funct3)
                3'b000:  aluCtrl = (opcode == `OPC_RTYPE && altOp) ? `ALU_SUB : `ALU_ADD;
                3'b001:  aluCtrl = `ALU_SLL;
                3'b010:  aluCtrl = `ALU_SLT;
                3'b100:  aluCtrl = `ALU_XOR;
                3'b101:  aluCtrl = altOp ? `ALU_SRA : `ALU_SRL;
                3'b110:  aluCtrl = `ALU_OR;
                3'b111:  aluCtrl = `ALU_AND;
                default: aluCtrl = `ALU_ADD;
            endcase
        end
    end

    always_comb begin
        case (opcode)
            `OPC_ITYPE, `OPC_LOAD: begin
                imm = {{(`XLEN-12){instr.iType.imm[11]}}, instr.iType.imm};
            end
            `OPC_STORE: begin
                imm = {{(`XLEN-12){instr.sType.immHi[6]}}, instr.sType.immHi,
                       instr.sType.immLo};
            end
            `OPC_BRANCH: begin
                imm = {{(`XLEN-12){instr.bType.imm12}}, instr.bType.imm11,
                       instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
            end
            `OPC_JAL: begin
                imm = {{(`XLEN-20){instr.jType.imm20}}, instr.jType.imm19to12,
                       instr.jType.imm11, instr.jType.imm10to1, 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== hazardUnit.sv ====
`include "rv_defines.svh"

module hazardUnit (
    input  rvIsaPkg::instrWord     idInstr,
    input  logic                   idBranch,
    input  logic [`REG_ADDR_W-1:0] exRs1,
    input  logic [`REG_ADDR_W-1:0] exRs2,
    input  logic [`REG_ADDR_W-1:0] exRd,
    input  logic                   exRegWrite,
    input  logic                   exMemRead,
    input  logic [`REG_ADDR_W-1:0] memRd,
    input  logic                   memRegWrite,
    input  logic                   memMemRead,
    input  logic [`REG_ADDR_W-1:0] wbRd,
    input  logic                   wbRegWrite,
    output logic [1:0]             fwdEx1,
    output logic [1:0]             fwdEx2,
    output logic [1:0]             fwdId1,
    output logic [1:0]             fwdId2,
    output logic                   stallId
);
    logic [`REG_ADDR_W-1:0] idRs1;
    logic [`REG_ADDR_W-1:0] idRs2;
    logic                   exLoadHit;
    logic                   exWriteHit;
    logic                   memLoadHit;

    // memory stage wins over writeback
    function automatic logic [1:0] fwdSel(input logic [`REG_ADDR_W-1:0] src);
        if (memRegWrite && memRd != '0 && memRd == src) begin
            return `FWD_MEM;
        end else if (wbRegWrite && wbRd != '0 && wbRd == src) begin
            return `FWD_WB;
        end
        return `FWD_REG;
    endfunction

    function automatic logic srcHit(input logic [`REG_ADDR_W-1:0] dst);
        return (dst != '0) && (dst == idRs1 || dst == idRs2);
    endfunction

    assign idRs1 = idInstr.rType.rs1;
    assign idRs2 = idInstr.rType.rs2;

    always_comb begin
        fwdEx1 = fwdSel(exRs1);
        fwdEx2 = fwdSel(exRs2);
        fwdId1 = fwdSel(idRs1);
        fwdId2 = fwdSel(idRs2);
    end

    always_comb begin
        exLoadHit  = exMemRead && srcHit(exRd);                // load-use
        exWriteHit = idBranch && exRegWrite && srcHit(exRd);   // branch needs ex result
        memLoadHit = idBranch && memMemRead && srcHit(memRd);  // branch needs load data
        stallId    = exLoadHit || exWriteHit || memLoadHit;
    end

endmodule

// ==== riscvPipeline.sv ====
`include "rv_defines.svh"

module riscvPipeline (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [`IMEM_ADDR_W-1:0] imemAddr,
    input  logic [`XLEN-1:0]        imemData,
    output logic                    dmemRead,
    output logic                    dmemWrite,
    output logic [`DMEM_ADDR_W-1:0] dmemAddr,
    output logic [`XLEN-1:0]        dmemWdata,
    input  logic [`XLEN-1:0]        dmemRdata,
    input  logic                    dmemStall
);
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       idPc;
    rvIsaPkg::instrWord     idInstr;
    logic                   idRegWrite, idMemRead, idMemWrite, idMemToReg, idAluSrc;
    logic                   idBranch, idJal, idBranchNe;
    logic [`ALU_CTRL_W-1:0] idAluCtrl;
    logic [`XLEN-1:0]       idImm, idRData1, idRData2, idOp1, idOp2, idTarget;
    logic [1:0]             fwdEx1, fwdEx2, fwdId1, fwdId2;
    logic                   stallId;
    logic                   redirect;

    logic [`XLEN-1:0]       exRData1, exRData2, exImm, exLink;
    logic [`XLEN-1:0]       exOpA, exOpB, exAluIn2, exAluOut;
    logic [`REG_ADDR_W-1:0] exRs1, exRs2, exRd;
    logic [`ALU_CTRL_W-1:0] exAluCtrl;
    logic                   exRegWrite, exMemRead, exMemWrite, exMemToReg, exAluSrc, exJal;

    logic [`XLEN-1:0]       memAluOut, memWdata, memLink, memValue;
    logic [`REG_ADDR_W-1:0] memRd;
    logic                   memRegWrite, memMemRead, memMemWrite, memMemToReg, memJal;

    logic [`XLEN-1:0]       wbLoadData, wbAluOut, wbLink, wbValue;
    logic [`REG_ADDR_W-1:0] wbRd;
    logic                   wbRegWrite, wbMemToReg, wbJal;

    function automatic logic [`XLEN-1:0] pickOperand(input logic [1:0] sel,
                                                     input logic [`XLEN-1:0] regVal,
                                                     input logic [`XLEN-1:0] memVal,
                                                     input logic [`XLEN-1:0] wbVal);
        case (sel)
            `FWD_MEM: return memVal;
            `FWD_WB:  return wbVal;
            default:  return regVal;
        endcase
    endfunction

    assign imemAddr = pc[`XLEN-1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!dmemStall && !stallId) begin
            pc <= redirect ? idTarget : pc + 4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idInstr <= '0;
        end else if (!dmemStall && !stallId) begin
            idInstr <= redirect ? '0 : imemData;  // flush on taken branch / jal
        end
    end

    always_ff @(posedge clk) begin
        if (!dmemStall && !stallId) begin
            idPc <= pc;
        end
    end

    instrDecoder instrDecoder_i (
        .instr(idInstr), .regWrite(idRegWrite), .memRead(idMemRead),
        .memWrite(idMemWrite), .memToReg(idMemToReg), .aluSrc(idAluSrc),
        .isBranch(idBranch), .isJal(idJal), .branchOnNe(idBranchNe),
        .aluCtrl(idAluCtrl), .imm(idImm)
    );

    regFile regFile_i (
        .clk(clk), .rst_n(rst_n), .rs1(idInstr.rType.rs1), .rs2(idInstr.rType.rs2),
        .rd(wbRd), .wData(wbValue), .we(wbRegWrite), .rData1(idRData1), .rData2(idRData2)
    );

    hazardUnit hazardUnit_i (
        .idInstr(idInstr), .idBranch(idBranch), .exRs1(exRs1), .exRs2(exRs2),
        .exRd(exRd), .exRegWrite(exRegWrite), .exMemRead(exMemRead), .memRd(memRd),
        .memRegWrite(memRegWrite), .memMemRead(memMemRead), .wbRd(wbRd),
        .wbRegWrite(wbRegWrite), .fwdEx1(fwdEx1), .fwdEx2(fwdEx2), .fwdId1(fwdId1),
        .fwdId2(fwdId2), .stallId(stallId)
    );

    // branch compare in decode
    assign idOp1    = pickOperand(fwdId1, idRData1, memValue, wbValue);
    assign idOp2    = pickOperand(fwdId2, idRData2, memValue, wbValue);
    assign idTarget = idPc + idImm;
    assign redirect = !stallId && (idJal || (idBranch && ((idOp1 == idOp2) != idBranchNe)));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            {exRegWrite, exMemRead, exMemWrite, exMemToReg, exJal} <= '0;
        end else if (!dmemStall) begin
            exRegWrite <= idRegWrite && !stallId;  // bubble on stall
            exMemRead  <= idMemRead && !stallId;
            exMemWrite <= idMemWrite && !stallId;
            exMemToReg <= idMemToReg && !stallId;
            exJal      <= idJal && !stallId;
        end
    end

    always_ff @(posedge clk) begin
        if (!dmemStall) begin
            exRData1  <= idRData1;
            exRData2  <= idRData2;
            exImm     <= idImm;
            exLink    <= idPc + 4;
            exRs1     <= idInstr.rType.rs1;
            exRs2     <= idInstr.rType.rs2;
            exRd      <= idInstr.rType.rd;
            exAluCtrl <= idAluCtrl;
            exAluSrc  <= idAluSrc;
        end
    end

    assign exOpA    = pickOperand(fwdEx1, exRData1, memValue, wbValue);
    assign exOpB    = pickOperand(fwdEx2, exRData2, memValue, wbValue);
    assign exAluIn2 = exAluSrc ? exImm : exOpB;

    aluUnit aluUnit_i (.a(exOpA), .b(exAluIn2), .aluCtrl(exAluCtrl), .result(exAluOut));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            {memRegWrite, memMemRead, memMemWrite, memMemToReg, memJal} <= '0;
        end else if (!dmemStall) begin
            memRegWrite <= exRegWrite;
            memMemRead  <= exMemRead;
            memMemWrite <= exMemWrite;
            memMemToReg <= exMemToReg;
            memJal      <= exJal;
        end
    end

    always_ff @(posedge clk) begin
        if (!dmemStall) begin
            memAluOut <= exAluOut;
            memWdata  <= exOpB;  // store data after forwarding
            memRd     <= exRd;
            memLink   <= exLink;
        end
    end

    assign dmemRead  = memMemRead;
    assign dmemWrite = memMemWrite;
    assign dmemAddr  = memAluOut[`XLEN-1:2];
    assign dmemWdata = memWdata;
    assign memValue  = memJal ? memLink : memAluOut;  // link forwards from memory too

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            {wbRegWrite, wbMemToReg, wbJal} <= '0;
        end else if (!dmemStall) begin
            wbRegWrite <= memRegWrite;
            wbMemToReg <= memMemToReg;
            wbJal      <= memJal;
        end
    end

    always_ff @(posedge clk) begin
        if (!dmemStall) begin
            wbLoadData <= dmemRdata;  // taken on the edge that ends the access
            wbAluOut   <= memAluOut;
            wbRd       <= memRd;
            wbLink     <= memLink;
        end
    end

    assign wbValue = wbJal ? wbLink : (wbMemToReg ? wbLoadData : wbAluOut);

endmodule

// ==== riscvPipeline_assertions.sv ====
`include "rv_defines.svh"

module riscvPipeline_assertions (
    input logic                    clk,
    input logic                    rst_n,
    input logic [`IMEM_ADDR_W-1:0] imemAddr,
    input logic                    dmemRead,
    input logic                    dmemWrite,
    input logic [`DMEM_ADDR_W-1:0] dmemAddr,
    input logic [`XLEN-1:0]        dmemWdata,
    input logic                    dmemStall
);
    timeunit 1ns;
    timeprecision 1ps;

    int assertFails = 0;

    // quiet through reset and the first cycle after it
    resetQuiet: assert property (@(posedge clk) !rst_n |=> (!dmemRead && !dmemWrite) [*2])
        else begin
            $error("data port request during or right after reset");
            assertFails++;
        end

    firstFetch: assert property (@(posedge clk) $rose(rst_n) |-> imemAddr == '0)
        else begin
            $error("first fetch after reset is not at address 0");
            assertFails++;
        end

    readOrWrite: assert property (@(posedge clk) disable iff (!rst_n)
                                  !(dmemRead && dmemWrite))
        else begin
            $error("read and write requested together");
            assertFails++;
        end

    holdOnStall: assert property (@(posedge clk) disable iff (!rst_n)
        dmemStall |=> $stable(dmemRead) && $stable(dmemWrite) && $stable(dmemAddr)
                      && $stable(dmemWdata) && $stable(imemAddr))
        else begin
            $error("port outputs moved while the data port stalled");
            assertFails++;
        end

endmodule

// ==== riscvPipelineTb.sv ====
`include "rv_defines.svh"

module riscvPipelineTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD    = 100;
    localparam int          NUM_RUNS      = 7;
    localparam int          MARGIN_CYCLES = 200;
    localparam logic [31:0] MARKER_ADDR   = 32'h100;  // byte address that ends a program

    logic                    clk;
    logic                    rst_n;
    logic [`IMEM_ADDR_W-1:0] imemAddr;
    logic [`XLEN-1:0]        imemData;
    logic                    dmemRead;
    logic                    dmemWrite;
    logic [`DMEM_ADDR_W-1:0] dmemAddr;
    logic [`XLEN-1:0]        dmemWdata;
    logic [`XLEN-1:0]        dmemRdata;
    logic                    dmemStall;

    logic [`XLEN-1:0] rom [64];
    logic [`XLEN-1:0] ram [128];
    logic [31:0]      expAddr [$];
    logic [31:0]      expData [$];
    logic [31:0]      gotAddr [$];
    logic [31:0]      gotData [$];
    logic [31:0]      lcgState;
    logic             stallOn;
    logic             tracing;
    logic             markerSeen;
    int               progLen;
    int               passCount;
    int               failCount;
    int               budgetCycles;
    string            testName;

    riscvPipeline riscvPipeline_i (
        .clk(clk), .rst_n(rst_n), .imemAddr(imemAddr), .imemData(imemData),
        .dmemRead(dmemRead), .dmemWrite(dmemWrite), .dmemAddr(dmemAddr),
        .dmemWdata(dmemWdata), .dmemRdata(dmemRdata), .dmemStall(dmemStall)
    );

    bind riscvPipeline riscvPipeline_assertions riscvPipeline_assertions_i (
        .clk(clk), .rst_n(rst_n), .imemAddr(imemAddr), .dmemRead(dmemRead),
        .dmemWrite(dmemWrite), .dmemAddr(dmemAddr), .dmemWdata(dmemWdata),
        .dmemStall(dmemStall)
    );

    assign imemData  = rom[imemAddr[5:0]];  // both ports answer in the same cycle
    assign dmemRdata = dmemRead ? ram[dmemAddr[6:0]] : '0;  // data only on a read request

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic logic [31:0] regOp(input int f7, input int f3, input int rd,
                                          input int rs1, input int rs2);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), `OPC_RTYPE};
    endfunction

    function automatic logic [31:0] immOp(input int f3, input int rd, input int rs1,
                                          input int imm);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), `OPC_ITYPE};
    endfunction

    function automatic logic [31:0] loadWord(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), 3'b010, 5'(rd), `OPC_LOAD};
    endfunction

    function automatic logic [31:0] storeWord(input int rs2, input int rs1, input int imm);
        logic [11:0] o;
        o = 12'(imm);
        return {o[11:5], 5'(rs2), 5'(rs1), 3'b010, o[4:0], `OPC_STORE};
    endfunction

    function automatic logic [31:0] branchTo(input int f3, input int rs1, input int rs2,
                                             input int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jumpLink(input int rd, input int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), `OPC_JAL};
    endfunction

    function automatic void emit(input logic [31:0] word);
        rom[progLen] = word;
        progLen++;
    endfunction

    // sw rs2 at a low address and record its hand-derived value
    function automatic void storeExpect(input int rs2, input logic [31:0] addr,
                                        input logic [31:0] value);
        emit(storeWord(rs2, 0, addr));
        expAddr.push_back(addr);
        expData.push_back(value);
    endfunction

    task automatic buildProgram(input int prog, input bit withStalls);
        string baseName;
        for (int i = 0; i < 64; i++) begin
            rom[i] = '0;
        end
        progLen = 0;
        expAddr.delete();
        expData.delete();
        case (prog)
            0: begin
                baseName = "alu";
                emit(immOp(0, 1, 0, 100));         // addi x1, x0, 100
                emit(immOp(0, 2, 0, -7));          // addi x2, x0, -7
                emit(regOp(7'h00, 0, 3, 1, 2));    // add
                emit(regOp(7'h20, 0, 4, 1, 2));    // sub
                emit(regOp(7'h00, 7, 5, 1, 2));    // and
                emit(regOp(7'h00, 6, 6, 1, 2));    // or
                emit(regOp(7'h00, 4, 7, 1, 2));    // xor
                emit(regOp(7'h00, 2, 8, 2, 1));    // slt x8, x2, x1
                emit(immOp(0, 11, 0, 3));
                emit(regOp(7'h00, 1, 12, 2, 11));  // sll
                emit(regOp(7'h00, 5, 13, 2, 11));  // srl
                emit(regOp(7'h20, 5, 14, 2, 11));  // sra
                emit(immOp(7, 15, 1, 12'h0f0));    // andi
                emit(immOp(6, 16, 15, 5));         // ori on the andi result
                emit(immOp(4, 17, 16, -1));        // xori
                emit(immOp(2, 18, 17, 0));         // slti
                emit(immOp(1, 19, 1, 4));          // slli
                emit(immOp(5, 20, 2, 28));         // srli
                emit(immOp(5, 21, 2, 12'h401));    // srai by 1
                storeExpect(3, 32'h00, 32'h0000005d);
                storeExpect(4, 32'h04, 32'h0000006b);
                storeExpect(5, 32'h08, 32'h00000060);
                storeExpect(6, 32'h0c, 32'hfffffffd);
                storeExpect(7, 32'h10, 32'hffffff9d);
                storeExpect(8, 32'h14, 32'h00000001);
                storeExpect(12, 32'h18, 32'hffffffc8);
                storeExpect(13, 32'h1c, 32'h1fffffff);
                storeExpect(14, 32'h20, 32'hffffffff);
                storeExpect(16, 32'h24, 32'h00000065);
                storeExpect(17, 32'h28, 32'hffffff9a);
                storeExpect(18, 32'h2c, 32'h00000001);
                storeExpect(19, 32'h30, 32'h00000640);
                storeExpect(20, 32'h34, 32'h0000000f);
                storeExpect(21, 32'h38, 32'hfffffffc);
            end
            1: begin
                baseName = "load";
                emit(immOp(0, 1, 0, 12'h123));
                storeExpect(1, 32'h40, 32'h00000123);
                emit(loadWord(2, 0, 32'h40));
                emit(immOp(0, 3, 2, 1));           // load-use
                storeExpect(3, 32'h44, 32'h00000124);
                emit(loadWord(4, 0, 32'h40));
                storeExpect(4, 32'h48, 32'h00000123);
            end
            2: begin
                baseName = "control";
                emit(immOp(0, 1, 0, 5));
                emit(immOp(0, 2, 0, 5));
                emit(branchTo(0, 1, 2, 8));        // beq taken once x2 leaves ex
                emit(storeWord(1, 0, 32'h7c));     // skipped
                emit(branchTo(1, 1, 2, 8));        // bne falls through
                storeExpect(1, 32'h50, 32'h00000005);
                emit(immOp(0, 3, 0, 9));
                emit(branchTo(1, 3, 1, 8));        // bne taken
                emit(storeWord(3, 0, 32'h78));     // skipped
                emit(branchTo(0, 3, 1, 8));        // beq falls through
                storeExpect(3, 32'h54, 32'h00000009);
                emit(jumpLink(4, 8));              // jal at byte 0x2c
                emit(storeWord(3, 0, 32'h74));     // skipped
                storeExpect(4, 32'h58, 32'h00000030);
            end
            default: begin
                baseName = "x0";
                emit(immOp(0, 0, 0, 55));          // write to x0 is dropped
                storeExpect(0, 32'h60, 32'h00000000);
                emit(immOp(0, 1, 0, 7));
                storeExpect(1, 32'h64, 32'h00000007);
            end
        endcase
        emit(storeWord(0, 0, MARKER_ADDR));
        testName = withStalls ? {baseName, "Stall"} : baseName;
    endtask

    task automatic fillRam();
        for (int i = 0; i < 128; i++) begin
            ram[i] = 32'h5a000000 ^ (i * 32'h00010203);
        end
    endtask

    task automatic checkTrace();
        int errs;
        errs = 0;
        assert (gotAddr.size() == expAddr.size()) else begin
            $display("%s: expected %0d stores before the marker but saw %0d",
                     testName, expAddr.size(), gotAddr.size());
            errs++;
        end
        for (int k = 0; k < expAddr.size() && k < gotAddr.size(); k++) begin
            assert (gotAddr[k] == expAddr[k]) else begin
                $display("mismatch %s store %0d address: expected %h actual %h",
                         testName, k, expAddr[k], gotAddr[k]);
                errs++;
            end
            assert (gotData[k] == expData[k]) else begin
                $display("mismatch %s store %0d data: expected %h actual %h",
                         testName, k, expData[k], gotData[k]);
                errs++;
            end
        end
        if (errs == 0) begin
            passCount++;
            $display("test %s: ok, %0d stores", testName, gotAddr.size());
        end else begin
            failCount++;
            $display("test %s: %0d errors", testName, errs);
        end
    endtask

    task automatic runTest(input int prog, input bit withStalls);
        stallOn <= 1'b0;
        tracing = 1'b0;
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        buildProgram(prog, withStalls);
        fillRam();
        gotAddr.delete();
        gotData.delete();
        markerSeen = 1'b0;
        tracing    = 1'b1;
        stallOn    <= withStalls;
        rst_n <= 1'b1;
        wait (markerSeen);
        tracing = 1'b0;
        checkTrace();
    endtask

    always @(posedge clk) begin : stallDriver
        logic [31:0] draw;
        draw = nextRandom();
        dmemStall <= stallOn && (draw[17:16] == 2'b00);  // about one edge in four
    end

    always @(posedge clk) begin : storeMonitor
        if (dmemWrite && !dmemStall) begin
            ram[dmemAddr[6:0]] <= dmemWdata;
            if (tracing && {dmemAddr, 2'b00} == MARKER_ADDR) begin
                markerSeen = 1'b1;
            end else if (tracing) begin
                gotAddr.push_back({dmemAddr, 2'b00});
                gotData.push_back(dmemWdata);
            end
        end
    end

    initial begin : watchdog
        wait (budgetCycles > 0);
        repeat (budgetCycles) @(posedge clk);
        $display("run did not finish within %0d cycles, no marker store in test %s",
                 budgetCycles, testName);
        $display("Testbench failed");
        $finish;
    end

    initial begin : mainSeq
        int total;
        rst_n        = 1'b0;
        dmemStall    = 1'b0;
        lcgState     = 32'h4f31;
        stallOn      = 1'b0;
        tracing      = 1'b0;
        markerSeen   = 1'b0;
        passCount    = 0;
        failCount    = 0;
        budgetCycles = 0;
        total        = 0;
        for (int r = 0; r < NUM_RUNS; r++) begin
            buildProgram(r % 4, 1'b0);
            total += progLen;
        end
        fillRam();
        budgetCycles = total * 8 + MARGIN_CYCLES;
        for (int r = 0; r < NUM_RUNS; r++) begin
            runTest(r % 4, r >= 4);  // last three runs repeat with data stalls
        end
        $display("tests: %0d ok, %0d with errors, %0d assertion failures", passCount,
                 failCount, riscvPipeline_i.riscvPipeline_assertions_i.assertFails);
        if (failCount == 0 && riscvPipeline_i.riscvPipeline_assertions_i.assertFails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
rvIsaPkg.sv
regFile.sv
aluUnit.sv
instrDecoder.sv
hazardUnit.sv
riscvPipeline.sv
riscvPipeline_assertions.sv
riscvPipelineTb.sv

// ==== Bender.yml ====
package:
  name: riscv_pipeline

export_include_dirs:
  - .

sources:
  - rvIsaPkg.sv
  - regFile.sv
  - aluUnit.sv
  - instrDecoder.sv
  - hazardUnit.sv
  - riscvPipeline.sv
  - target: test
    files:
      - riscvPipeline_assertions.sv
      - riscvPipelineTb.sv
